// ==== Bender.yml ====
package:
  name: fetch_front_end

sources:
  - logic/rv_isa_pkg.sv
  - logic/fetch_pkg.sv
  - logic/branch_history_table.sv
  - logic/fetch_pc_gen.sv
  - logic/fetch_queue.sv
  - logic/inst_serializer.sv
  - logic/fetch_top.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/fetch_tb.sv

// ==== logic/branch_history_table.sv ====
/*
 * Two-bit saturating branch predictor.
 * Fetch reads a prediction combinationally, the back end trains it by strobe.
 */
`default_nettype none

module branch_history_table
    import fetch_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 i_reset,
    input  wire logic [BHT_IDX_W-1:0] i_rd_idx,
    output logic                      o_predict_taken,
    input  wire logic                 i_bht_update,
    input  wire logic [XLEN-1:0]      i_bht_update_pc,
    input  wire logic                 i_bht_update_taken
);

    logic [1:0] counters [BHT_ENTRIES];
    logic [BHT_IDX_W-1:0] upd_idx;

    assign upd_idx = i_bht_update_pc[BHT_IDX_W+1:2];

    // 2 and 3 predict taken
    assign o_predict_taken = counters[i_rd_idx][1];

    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                counters[i] <= 2'd1;   // weakly not taken
            end
        end else if (i_bht_update) begin
            if (i_bht_update_taken && counters[upd_idx] != 2'd3) begin
                counters[upd_idx] <= counters[upd_idx] + 2'd1;
            end else if (!i_bht_update_taken && counters[upd_idx] != 2'd0) begin
                counters[upd_idx] <= counters[upd_idx] - 2'd1;
            end
        end
    end

    // back end trains only on real instruction addresses
    a_update_aligned: assert property (
        @(posedge clk) disable iff (i_reset)
        i_bht_update |-> (i_bht_update_pc[1:0] == 2'b00)
    );

endmodule

`default_nettype wire

// ==== logic/fetch_pc_gen.sv ====
/*
 * Fetch PC generator. Predecodes the four slots of the current line,
 * predicts the next PC and pushes the line into the fetch queue.
 * Back-end redirects win over prediction and are held across a cache miss.
 */
`default_nettype none

module fetch_pc_gen
    import rv_isa_pkg::*;
    import fetch_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 i_reset,
    input  wire logic [LINE_W-1:0]    i_line,
    input  wire logic                 i_cache_miss,
    output logic      [XLEN-1:0]      o_fetch_pc,
    output logic      [4:0]           o_jreg_addr,
    output logic                      o_jreg_valid,
    input  wire logic [XLEN-1:0]      i_jreg_data,
    output logic      [BHT_IDX_W-1:0] o_bht_idx,
    input  wire logic                 i_predict_taken,
    input  wire logic                 i_full,
    input  wire logic                 i_fix_valid,
    input  wire logic [XLEN-1:0]      i_fix_pc,
    input  wire logic                 i_trap_valid,
    input  wire logic [XLEN-1:0]      i_trap_pc,
    output logic                      o_push,
    output logic      [LINE_W-1:0]    o_push_line,
    output logic      [XLEN-1:0]      o_push_pc,
    output logic      [COUNT_W-1:0]   o_push_count,
    output logic                      o_flush
);

    logic [INST_W-1:0]      slot_inst [FETCH_WIDTH];
    logic [XLEN-1:0]        slot_pc   [FETCH_WIDTH];
    logic [FETCH_WIDTH-1:0] live, is_jal, is_jalr, is_br, taken;
    logic [XLEN-1:0]        line_base, target, next_pc;
    logic [SLOT_IDX_W-1:0]  cur_slot, br_sel, jr_sel, tk_sel;
    logic                   br_found, tk_found;
    logic                   redir_valid, pend_valid;
    logic [XLEN-1:0]        redir_pc, pend_pc;

    assign line_base = {o_fetch_pc[XLEN-1:SLOT_IDX_W+2], {(SLOT_IDX_W+2){1'b0}}};
    assign cur_slot  = o_fetch_pc[SLOT_IDX_W+1:2];

    // predecode every slot of the line
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            slot_inst[i] = i_line[i*INST_W +: INST_W];
            slot_pc[i]   = line_base + XLEN'(i * 4);
            live[i]      = (i >= cur_slot);
            is_jal[i]    = slot_inst[i][6:2] == OPC_JAL    && slot_inst[i][1:0] == OPC_LOW;
            is_jalr[i]   = slot_inst[i][6:2] == OPC_JALR   && slot_inst[i][1:0] == OPC_LOW;
            is_br[i]     = slot_inst[i][6:2] == OPC_BRANCH && slot_inst[i][1:0] == OPC_LOW;
        end
    end

    // first live branch gets the prediction, first live jalr reads the register file
    always_comb begin
        br_found     = 1'b0;
        br_sel       = '0;
        o_jreg_valid = 1'b0;
        jr_sel       = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (live[i] && is_br[i] && !br_found) begin
                br_found = 1'b1;
                br_sel   = SLOT_IDX_W'(i);
            end
            if (live[i] && is_jalr[i] && !o_jreg_valid) begin
                o_jreg_valid = 1'b1;
                jr_sel       = SLOT_IDX_W'(i);
            end
        end
    end

    assign o_bht_idx   = slot_pc[br_sel][BHT_IDX_W+1:2];
    assign o_jreg_addr = slot_inst[jr_sel][19:15];   // rs1

    // first redirecting slot ends the line
    always_comb begin
        tk_found = 1'b0;
        tk_sel   = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            taken[i] = live[i] && (is_jal[i] || is_jalr[i] ||
                       (is_br[i] && br_found && br_sel == SLOT_IDX_W'(i) && i_predict_taken));
            if (taken[i] && !tk_found) begin
                tk_found = 1'b1;
                tk_sel   = SLOT_IDX_W'(i);
            end
        end
    end

    always_comb begin
        logic [20:0] j_off;
        logic [12:0] b_off;
        logic [11:0] i_off;
        j_off = imm_j(slot_inst[tk_sel]);
        b_off = imm_b(slot_inst[tk_sel]);
        i_off = imm_i(slot_inst[tk_sel]);
        if (is_jal[tk_sel]) begin
            target = slot_pc[tk_sel] + {{(XLEN-21){j_off[20]}}, j_off};
        end else if (is_jalr[tk_sel]) begin
            target = i_jreg_data + {{(XLEN-12){i_off[11]}}, i_off};
            target[0] = 1'b0;
        end else begin
            target = slot_pc[tk_sel] + {{(XLEN-13){b_off[12]}}, b_off};
        end
    end

    assign next_pc = tk_found ? target : line_base + XLEN'(LINE_W / 8);

    assign o_push_count = tk_found ? COUNT_W'(tk_sel) - COUNT_W'(cur_slot) + 1'b1
                                   : COUNT_W'(FETCH_WIDTH) - COUNT_W'(cur_slot);

    assign redir_valid = i_fix_valid || i_trap_valid;
    assign redir_pc    = i_fix_valid ? i_fix_pc : i_trap_pc;   // fix wins

    // a held redirect also means the current line is on the old path
    assign o_push      = !i_cache_miss && !redir_valid && !pend_valid && !i_full;
    assign o_push_line = i_line;
    assign o_push_pc   = o_fetch_pc;
    assign o_flush     = redir_valid;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_fetch_pc <= RESET_PC;
            pend_valid <= 1'b0;
        end else if (i_cache_miss) begin
            if (redir_valid) begin   // park until the miss ends
                pend_valid <= 1'b1;
                pend_pc    <= redir_pc;
            end
        end else begin
            pend_valid <= 1'b0;
            if (redir_valid) begin
                o_fetch_pc <= redir_pc;
            end else if (pend_valid) begin
                o_fetch_pc <= pend_pc;
            end else if (!i_full) begin
                o_fetch_pc <= next_pc;
            end
        end
    end

    a_pc_aligned: assert property (
        @(posedge clk) disable iff (i_reset)
        o_fetch_pc[1:0] == 2'b00
    );

    a_push_count: assert property (
        @(posedge clk) disable iff (i_reset)
        o_push |-> (o_push_count >= COUNT_W'(1) && o_push_count <= COUNT_W'(FETCH_WIDTH))
    );

endmodule

`default_nettype wire

// ==== logic/fetch_pkg.sv ====
/*
 * Geometry and sizing of the fetch front end.
 * Shared by the PC generator, history table, fetch queue and serializer.
 */
`default_nettype none

package fetch_pkg;

    localparam int unsigned XLEN = 64;
    localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

    // one fetch line holds four 32-bit slots
    localparam int unsigned FETCH_WIDTH = 4;
    localparam int unsigned LINE_W      = 128;
    localparam int unsigned SLOT_IDX_W  = 2;   // pc bits 3:2
    localparam int unsigned COUNT_W     = 3;   // 1..4 live slots

    localparam int unsigned QUEUE_DEPTH = 4;

    // indexed by pc bits 5:2
    localparam int unsigned BHT_ENTRIES = 16;
    localparam int unsigned BHT_IDX_W   = 4;

endpackage

`default_nettype wire

// ==== logic/fetch_queue.sv ====
/*
 * Circular queue of fetched lines between the PC generator and the serializer.
 * Each entry keeps the line, its fetch PC and the number of live slots.
 */
`default_nettype none

module fetch_queue
    import fetch_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               i_reset,
    input  wire logic               i_flush,
    input  wire logic               i_push,
    input  wire logic [LINE_W-1:0]  i_push_line,
    input  wire logic [XLEN-1:0]    i_push_pc,
    input  wire logic [COUNT_W-1:0] i_push_count,
    output logic                    o_full,
    input  wire logic               i_pop,
    output logic      [LINE_W-1:0]  o_head_line,
    output logic      [XLEN-1:0]    o_head_pc,
    output logic      [COUNT_W-1:0] o_head_count,
    output logic                    o_empty
);

    logic [LINE_W-1:0]  line_q  [QUEUE_DEPTH];
    logic [XLEN-1:0]    pc_q    [QUEUE_DEPTH];
    logic [COUNT_W-1:0] count_q [QUEUE_DEPTH];

    logic [$clog2(QUEUE_DEPTH)-1:0] wr_ptr, rd_ptr;
    logic [$clog2(QUEUE_DEPTH):0]   occupancy;
    logic do_push, do_pop;

    assign o_full  = occupancy == QUEUE_DEPTH;
    assign o_empty = occupancy == 0;
    assign do_push = i_push && !o_full;
    assign do_pop  = i_pop && !o_empty;

    assign o_head_line  = line_q[rd_ptr];
    assign o_head_pc    = pc_q[rd_ptr];
    assign o_head_count = count_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            line_q[wr_ptr]  <= i_push_line;
            pc_q[wr_ptr]    <= i_push_pc;
            count_q[wr_ptr] <= i_push_count;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset || i_flush) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            occupancy <= occupancy + do_push - do_pop;
        end
    end

    // generator and serializer both honour the flags
    a_no_push_full: assert property (
        @(posedge clk) disable iff (i_reset)
        i_push |-> !o_full
    );

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (i_reset)
        i_pop |-> !o_empty
    );

endmodule

`default_nettype wire

// ==== logic/fetch_top.sv ====
/*
 * Fetch front end top level. Instruction memory and register file
 * sit outside and answer the fetch PC and jalr register address.
 */
`default_nettype none

module fetch_top
    import rv_isa_pkg::*;
    import fetch_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              i_reset,
    output logic      [XLEN-1:0]   o_fetch_pc,
    input  wire logic [LINE_W-1:0] i_line,
    input  wire logic              i_cache_miss,
    output logic      [4:0]        o_jreg_addr,
    output logic                   o_jreg_valid,
    input  wire logic [XLEN-1:0]   i_jreg_data,
    input  wire logic              i_fix_valid,
    input  wire logic [XLEN-1:0]   i_fix_pc,
    input  wire logic              i_trap_valid,
    input  wire logic [XLEN-1:0]   i_trap_pc,
    input  wire logic              i_bht_update,
    input  wire logic [XLEN-1:0]   i_bht_update_pc,
    input  wire logic              i_bht_update_taken,
    input  wire logic              i_issue_stall,
    output logic                   o_inst_valid,
    output logic      [INST_W-1:0] o_inst,
    output logic      [XLEN-1:0]   o_inst_pc
);

    logic [BHT_IDX_W-1:0] bht_idx;
    logic                 predict_taken;
    logic                 push, full, flush, pop, empty;
    logic [LINE_W-1:0]    push_line, head_line;
    logic [XLEN-1:0]      push_pc, head_pc;
    logic [COUNT_W-1:0]   push_count, head_count;

    fetch_pc_gen pc_gen_i (
        .clk, .i_reset, .i_line, .i_cache_miss, .o_fetch_pc,
        .o_jreg_addr, .o_jreg_valid, .i_jreg_data,
        .o_bht_idx(bht_idx), .i_predict_taken(predict_taken), .i_full(full),
        .i_fix_valid, .i_fix_pc, .i_trap_valid, .i_trap_pc,
        .o_push(push), .o_push_line(push_line), .o_push_pc(push_pc),
        .o_push_count(push_count), .o_flush(flush)
    );

    branch_history_table bht_i (
        .clk, .i_reset, .i_rd_idx(bht_idx), .o_predict_taken(predict_taken),
        .i_bht_update, .i_bht_update_pc, .i_bht_update_taken
    );

    fetch_queue queue_i (
        .clk, .i_reset, .i_flush(flush),
        .i_push(push), .i_push_line(push_line), .i_push_pc(push_pc),
        .i_push_count(push_count), .o_full(full), .i_pop(pop),
        .o_head_line(head_line), .o_head_pc(head_pc), .o_head_count(head_count),
        .o_empty(empty)
    );

    inst_serializer serializer_i (
        .clk, .i_reset, .i_flush(flush), .i_empty(empty),
        .i_head_line(head_line), .i_head_pc(head_pc), .i_head_count(head_count),
        .o_pop(pop), .i_issue_stall, .o_inst_valid, .o_inst, .o_inst_pc
    );

endmodule

`default_nettype wire

// ==== logic/inst_serializer.sv ====
/*
 * Unpacks queued fetch lines into one instruction per cycle for issue.
 * Next line is requested as the last slot of the current one goes out.
 */
`default_nettype none

module inst_serializer
    import rv_isa_pkg::*;
    import fetch_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               i_reset,
    input  wire logic               i_flush,
    input  wire logic               i_empty,
    input  wire logic [LINE_W-1:0]  i_head_line,
    input  wire logic [XLEN-1:0]    i_head_pc,
    input  wire logic [COUNT_W-1:0] i_head_count,
    output logic                    o_pop,
    input  wire logic               i_issue_stall,
    output logic                    o_inst_valid,
    output logic      [INST_W-1:0]  o_inst,
    output logic      [XLEN-1:0]    o_inst_pc
);

    logic [LINE_W-1:0]     cur_line;
    logic [XLEN-1:0]       cur_pc;
    logic [SLOT_IDX_W-1:0] slot_idx;
    logic [COUNT_W-1:0]    slots_left;
    logic                  have_line, last_slot;

    assign last_slot = have_line && slots_left == COUNT_W'(1);
    assign o_pop     = !i_empty && (!have_line || (last_slot && !i_issue_stall));

    always_ff @(posedge clk) begin
        if (i_reset || i_flush) begin
            have_line    <= 1'b0;
            o_inst_valid <= 1'b0;
        end else begin
            if (!i_issue_stall) begin
                o_inst_valid <= have_line;
                if (have_line) begin
                    o_inst    <= cur_line[slot_idx*INST_W +: INST_W];
                    o_inst_pc <= cur_pc;
                end
            end
            if (o_pop) begin
                have_line  <= 1'b1;
                cur_line   <= i_head_line;
                cur_pc     <= i_head_pc;
                slot_idx   <= i_head_pc[SLOT_IDX_W+1:2];   // may start mid-line
                slots_left <= i_head_count;
            end else if (have_line && !i_issue_stall) begin
                if (last_slot) begin
                    have_line <= 1'b0;   // queue ran dry
                end
                cur_pc     <= cur_pc + XLEN'(4);
                slot_idx   <= slot_idx + 1'b1;
                slots_left <= slots_left - 1'b1;
            end
        end
    end

    // issue sees a frozen beat unless the path is flushed
    a_stall_hold: assert property (
        @(posedge clk) disable iff (i_reset)
        (i_issue_stall && o_inst_valid && !i_flush) |=>
            (o_inst_valid && $stable(o_inst) && $stable(o_inst_pc))
    );

endmodule

`default_nettype wire

// ==== logic/rv_isa_pkg.sv ====
/*
 * RISC-V base ISA fields used by the fetch predecoder.
 * Covers major opcodes and the raw immediate layouts of J, B and I formats.
 */
`default_nettype none

package rv_isa_pkg;

    localparam int unsigned INST_W = 32;

    // major opcode, bits 6:2
    localparam logic [4:0] OPC_JAL    = 5'b11011;
    localparam logic [4:0] OPC_JALR   = 5'b11001;
    localparam logic [4:0] OPC_BRANCH = 5'b11000;
    localparam logic [1:0] OPC_LOW    = 2'b11;   // uncompressed encoding

    // byte offset, bit 0 always zero, sign in bit 20
    function automatic logic [20:0] imm_j(input logic [INST_W-1:0] inst);
        return {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

    // byte offset, sign in bit 12
    function automatic logic [12:0] imm_b(input logic [INST_W-1:0] inst);
        return {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

    function automatic logic [11:0] imm_i(input logic [INST_W-1:0] inst);
        return inst[31:20];
    endfunction

endpackage

`default_nettype wire

// ==== sim/fetch_tb_model.svh ====
/*
 * Program image, expected-stream walker and LFSR for the fetch testbench.
 * Included inside fetch_tb, where it works on the memory and register models.
 */
`ifndef FETCH_TB_MODEL_SVH
`define FETCH_TB_MODEL_SVH

logic [15:0] lfsr = 16'd27;

// default word is addi x1, x0, imm with imm folded from every address bit
function automatic logic [31:0] mem_word(input logic [63:0] addr);
    logic [11:0] imm;
    if (imem.exists(addr)) return imem[addr];
    imm = '0;
    for (int i = 2; i < 64; i++) begin
        imm[(i - 2) % 12] ^= addr[i];
    end
    return {imm, 5'd0, 3'b000, 5'd1, 7'b0010011};
endfunction

// places a control transfer and records what it should do
function automatic void put_ctl(input logic [63:0] a, input int kind, input longint off,
                                input int rs1);
    logic [20:0] j;
    logic [12:0] b;
    j = 21'(off);
    b = 13'(off);
    case (kind)
        K_JAL:   imem[a] = {j[20], j[10:1], j[11], j[19:12], 5'd0, 7'b1101111};
        K_JALR:  imem[a] = {12'(off), 5'(rs1), 3'b000, 5'd0, 7'b1100111};
        default: imem[a] = {b[12], b[10:5], 5'd2, 5'd1, 3'b000, b[4:1], b[11], 7'b1100011};
    endcase
    ctl_kind[a] = kind;
    ctl_off[a]  = off;
    ctl_rs1[a]  = rs1;
endfunction

// walks lines from start, only the first branch of a line is predicted
function automatic void build_expected(input logic [63:0] start, input int n);
    logic [63:0] pc, a, line_end, nxt;
    bit stop, br_seen;
    int k;
    exp_inst.delete();
    exp_pc.delete();
    pc = start;
    while (exp_pc.size() < n) begin
        line_end = {pc[63:4], 4'h0} + 64'd16;
        nxt      = line_end;
        stop     = 0;
        br_seen  = 0;
        a        = pc;
        while (!stop && a != line_end) begin
            exp_inst.push_back(mem_word(a));
            exp_pc.push_back(a);
            if (ctl_kind.exists(a)) begin
                k = ctl_kind[a];
                if (k == K_JAL || (k == K_BR && !br_seen && bht_model[a[5:2]] >= 2)) begin
                    nxt  = a + ctl_off[a];
                    stop = 1;
                end else if (k == K_JALR) begin
                    nxt  = (regs[ctl_rs1[a]] + ctl_off[a]) & ~64'h1;
                    stop = 1;
                end
                br_seen |= (k == K_BR);
            end
            a += 64'd4;
        end
        pc = nxt;
    end
endfunction

// galois form, one step per bit
function automatic bit next_bit();
    bit out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) lfsr ^= 16'hB400;
    return out;
endfunction

`endif

// ==== sim/fetch_tb.sv ====
/*
 * Testbench for the fetch front end. Models instruction memory and the
 * register file, collects issued instructions and runs directed tests.
 */
`default_nettype none

module fetch_tb
    import rv_isa_pkg::*;
    import fetch_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int K_JAL      = 1;
    localparam int K_JALR     = 2;
    localparam int K_BR       = 3;
    localparam int TEST_BEATS = 144;   // beats checked over all tests

    logic                clk, i_reset, i_cache_miss, o_jreg_valid, i_issue_stall;
    logic                i_fix_valid, i_trap_valid, i_bht_update, i_bht_update_taken;
    logic                o_inst_valid;
    logic [XLEN-1:0]     o_fetch_pc, i_jreg_data, i_fix_pc, i_trap_pc, i_bht_update_pc;
    logic [XLEN-1:0]     o_inst_pc;
    logic [LINE_W-1:0]   i_line;
    logic [4:0]          o_jreg_addr;
    logic [INST_W-1:0]   o_inst;

    logic [31:0] imem [logic [63:0]];
    int          ctl_kind [logic [63:0]];
    longint      ctl_off [logic [63:0]];
    int          ctl_rs1 [logic [63:0]];
    logic [63:0] regs [32];
    logic [1:0]  bht_model [16];
    logic [31:0] got_inst [$];
    logic [31:0] exp_inst [$];
    logic [63:0] got_pc [$];
    logic [63:0] exp_pc [$];
    logic [31:0] jreg_seen;
    int          checks, errors;

    `include "fetch_tb_model.svh"

    fetch_top dut_i (.*);

    // memory answers the whole aligned line in the same cycle
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            i_line[i*INST_W +: INST_W] = mem_word({o_fetch_pc[XLEN-1:4], 4'h0} + XLEN'(i * 4));
        end
    end

    assign i_jreg_data = regs[o_jreg_addr];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (!i_reset && o_inst_valid === 1'b1 && !i_issue_stall) begin
            got_inst.push_back(o_inst);
            got_pc.push_back(o_inst_pc);
        end
        if (!i_reset && o_jreg_valid === 1'b1) jreg_seen[o_jreg_addr] = 1'b1;
    end

    initial begin
        repeat (TEST_BEATS * 40) @(posedge clk);
        $display("timeout: the expected instruction stream did not arrive in time");
        $display("STATUS: FAIL");
        $finish;
    end

    // redirect strobe for one cycle, then drop what the old path delivered
    task automatic restart(input bit fix, input logic [63:0] fix_pc,
                           input bit trap, input logic [63:0] trap_pc);
        @(negedge clk);
        i_fix_valid  = fix;
        i_fix_pc     = fix_pc;
        i_trap_valid = trap;
        i_trap_pc    = trap_pc;
        @(negedge clk);
        i_fix_valid  = 1'b0;
        i_trap_valid = 1'b0;
        got_inst.delete();
        got_pc.delete();
        jreg_seen = '0;
    endtask

    task automatic check_stream(input string name, input logic [63:0] start, input int n);
        build_expected(start, n);
        while (got_pc.size() < n) @(negedge clk);
        for (int i = 0; i < n; i++) begin
            checks += 2;
            assert (got_pc[i] == exp_pc[i]) else begin
                errors++;
                $display("Mismatch %s o_inst_pc[%0d]: got %h, expected %h",
                         name, i, got_pc[i], exp_pc[i]);
            end
            assert (got_inst[i] == exp_inst[i]) else begin
                errors++;
                $display("Mismatch %s o_inst[%0d]: got %h, expected %h",
                         name, i, got_inst[i], exp_inst[i]);
            end
        end
    endtask

    task automatic train(input logic [63:0] pc, input bit tk);
        @(negedge clk);
        i_bht_update       = 1'b1;
        i_bht_update_pc    = pc;
        i_bht_update_taken = tk;
        if (tk && bht_model[pc[5:2]] != 2'd3) bht_model[pc[5:2]]++;
        else if (!tk && bht_model[pc[5:2]] != 2'd0) bht_model[pc[5:2]]--;
        @(negedge clk);
        i_bht_update = 1'b0;
    endtask

    task automatic test_sequential();
        check_stream("seq reset", RESET_PC, 12);
        restart(1, RESET_PC + 64'h1008, 0, '0);   // starts at slot 2
        check_stream("seq unaligned", RESET_PC + 64'h1008, 12);
    endtask

    task automatic test_jal();
        logic [63:0] p;
        p = 64'h8000_2000;
        put_ctl(p + 64'h4, K_JAL, 64'h40, 0);
        put_ctl(p + 64'h48, K_JAL, -60, 0);   // back to p+c
        restart(1, p, 0, '0);
        check_stream("jal", p, 16);
    endtask

    task automatic test_branch();
        logic [63:0] p;
        p = 64'h8000_4000;
        put_ctl(p + 64'h8, K_BR, 64'h80, 0);
        restart(1, p, 0, '0);
        check_stream("branch not taken", p, 8);
        train(p + 64'h8, 1);
        train(p + 64'h8, 1);
        restart(1, p, 0, '0);
        check_stream("branch taken", p, 8);
    endtask

    task automatic test_jalr();
        logic [63:0] p;
        p = 64'h8000_3000;
        regs[7] = 64'h8000_3200;
        regs[9] = 64'h8000_3041;
        put_ctl(p + 64'h4, K_JALR, 64'hD, 7);   // odd sum, bit 0 dropped
        put_ctl(p + 64'h20C, K_JALR, -49, 9);
        restart(1, p, 0, '0);
        check_stream("jalr", p, 10);
        checks++;
        assert (jreg_seen == 32'h0000_0280) else begin
            errors++;
            $display("Mismatch o_jreg_addr set: got %h, expected %h", jreg_seen, 32'h280);
        end
    endtask

    task automatic test_redirect();
        logic [63:0] p, held_pc;
        p = 64'h8000_5000;
        restart(1, p, 1, 64'h8000_6000);
        check_stream("fix over trap", p, 8);
        @(negedge clk);
        i_cache_miss = 1'b1;
        held_pc = o_fetch_pc;
        restart(1, p + 64'hA00, 0, '0);
        restart(0, '0, 1, p + 64'h104);   // newer one replaces the held target
        repeat (2) @(negedge clk);
        checks++;
        assert (o_fetch_pc == held_pc) else begin
            errors++;
            $display("Mismatch o_fetch_pc under miss: got %h, expected %h", o_fetch_pc, held_pc);
        end
        i_cache_miss = 1'b0;
        check_stream("redirect under miss", p + 64'h104, 10);
    endtask

    task automatic test_backpressure();
        logic [63:0] p;
        p = 64'h8000_8000;
        put_ctl(p + 64'h8, K_BR, 64'h20, 0);     // shares the trained counter
        put_ctl(p + 64'h2C, K_BR, 64'h100, 0);
        put_ctl(p + 64'h34, K_JAL, -52, 0);
        restart(1, p, 0, '0);
        while (got_pc.size() < 60) begin
            @(negedge clk);
            i_issue_stall = next_bit();
            i_cache_miss  = next_bit() & next_bit();
        end
        i_issue_stall = 1'b0;
        i_cache_miss  = 1'b0;
        check_stream("back-pressure", p, 60);
    endtask

    initial begin
        i_reset            = 1'b1;
        i_cache_miss       = 1'b0;
        i_fix_valid        = 1'b0;
        i_fix_pc           = '0;
        i_trap_valid       = 1'b0;
        i_trap_pc          = '0;
        i_bht_update       = 1'b0;
        i_bht_update_pc    = '0;
        i_bht_update_taken = 1'b0;
        i_issue_stall      = 1'b0;
        checks             = 0;
        errors             = 0;
        jreg_seen          = '0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = 64'h8000_7000 + 64'(i * 256);
        end
        regs[0] = '0;
        for (int i = 0; i < 16; i++) begin
            bht_model[i] = 2'd1;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        i_reset = 1'b0;
        test_sequential();
        test_jal();
        test_branch();
        test_jalr();
        test_redirect();
        test_backpressure();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+sim
logic/rv_isa_pkg.sv
logic/fetch_pkg.sv
logic/branch_history_table.sv
logic/fetch_pc_gen.sv
logic/fetch_queue.sv
logic/inst_serializer.sv
logic/fetch_top.sv
sim/fetch_tb.sv
